// ==== psPixelXfer.f ====
+incdir+verilog
verilog/pixelXferPkg.sv
verilog/xferRegs.sv
verilog/xferCtrl.sv
verilog/pixelCounter.sv
verilog/rgbPacker.sv
verilog/wordFifo.sv
verilog/pixelXferTop.sv
sim/pixelXferTb.sv

// ==== sim/pixelXferTb.sv ====
// Table-driven testbench for the pixel readback path, drives LFSR pixels and an AXI4-Lite host
`timescale 1ns/1ps
`include "pixelXfer_cfg.svh"

module pixelXferTb import pixelXferPkg::*; ();

	localparam int         NUM_ROWS    = 9;
	localparam logic [1:0] STALL_NONE  = 2'd0;
	localparam logic [1:0] STALL_SRC   = 2'd1;	// Random gaps in pixel valid
	localparam logic [1:0] STALL_HOST  = 2'd2;	// Host lets the FIFO fill first
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		pixFmt_e     fmt;
		logic        mask;
		logic [15:0] groups;
		logic [1:0]  stall;
		logic        restart;	// Second start written while busy
	} testRow_t;

	logic                    i_clk;
	logic                    i_nrst;
	logic                    i_awvalid;
	logic                    o_awready;
	logic [`XFER_ADDR_W-1:0] i_awaddr;
	logic                    i_wvalid;
	logic                    o_wready;
	logic [31:0]             i_wdata;
	logic                    o_bvalid;
	logic                    i_bready;
	logic [1:0]              o_bresp;
	logic                    i_arvalid;
	logic                    o_arready;
	logic [`XFER_ADDR_W-1:0] i_araddr;
	logic                    o_rvalid;
	logic                    i_rready;
	logic [31:0]             o_rdata;
	logic [1:0]              o_rresp;
	logic                    i_pixValid;
	rgbPix_t                 i_pix;
	logic                    o_pixReady;

	testRow_t    rows [NUM_ROWS];
	rgbPix_t     pixQ [$];	// Pixels of the current row
	logic [31:0] expQ [$];	// Expected DATA words, in order
	logic [31:0] lfsr       = 32'h0e6b2fe6;
	int          cycleLimit = 0;

	pixelXferTop i_dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsrBit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] lfsrBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], lfsrBit()};	// One step per bit
		return v;
	endfunction

	function automatic int wordsPerGroup(input pixFmt_e fmt);
		case (fmt)
		FMT_04BIT: return 1;
		FMT_08BIT: return 2;
		FMT_24BIT: return 6;
		default:   return 4;
		endcase
	endfunction

	function automatic testRow_t makeRow(input pixFmt_e fmt, input logic mask, input int groups,
		input logic [1:0] stall, input logic restart);
		testRow_t row;
		row.fmt     = fmt;
		row.mask    = mask;
		row.groups  = groups[15:0];
		row.stall   = stall;
		row.restart = restart;
		return row;
	endfunction

	task automatic reportError(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "Stopped at the first error");
	endtask

	// Reference packing from the format rules
	task automatic buildRow(input testRow_t row);
		logic [31:0] w;
		logic [31:0] bits;
		logic [7:0]  bytes [$];	// 24-bit byte stream R G B per pixel
		rgbPix_t     px;
		pixQ.delete();
		expQ.delete();
		w = '0;
		for (int i = 0; i < row.groups * 8; i++) begin
			bits = lfsrBits(24);
			px   = bits[23:0];
			pixQ.push_back(px);
			case (row.fmt)
			FMT_04BIT: w[4*(i%8) +: 4] = px.r[7:4];
			FMT_08BIT: w[8*(i%4) +: 8] = px.r;
			FMT_15BIT: w[16*(i%2) +: 16] = {row.mask, px.b[7:3], px.g[7:3], px.r[7:3]};
			default: begin
				bytes.push_back(px.r);
				bytes.push_back(px.g);
				bytes.push_back(px.b);
			end
			endcase
			if ((row.fmt == FMT_04BIT && i % 8 == 7) || (row.fmt == FMT_08BIT && i % 4 == 3)
				|| (row.fmt == FMT_15BIT && i % 2 == 1))
				expQ.push_back(w);
		end
		for (int j = 0; j + 3 < bytes.size(); j += 4)
			expQ.push_back({bytes[j+3], bytes[j+2], bytes[j+1], bytes[j]});	// Little-endian
	endtask

	task automatic writeReg(input logic [`XFER_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(posedge i_clk);
		i_awvalid <= 1'b1;
		i_wvalid  <= 1'b1;
		i_awaddr  <= addr;
		i_wdata   <= data;
		do @(posedge i_clk); while (!(o_awready && o_wready));
		i_awvalid <= 1'b0;
		i_wvalid  <= 1'b0;
		i_bready  <= 1'b1;
		do @(posedge i_clk); while (!o_bvalid);
		resp = o_bresp;
		i_bready <= 1'b0;
	endtask

	task automatic readReg(input logic [`XFER_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge i_clk);
		i_arvalid <= 1'b1;
		i_araddr  <= addr;
		do @(posedge i_clk); while (!o_arready);
		i_arvalid <= 1'b0;
		i_rready  <= 1'b1;
		do @(posedge i_clk); while (!o_rvalid);
		data = o_rdata;
		resp = o_rresp;
		i_rready <= 1'b0;
	endtask

	// Pixel source, valid held until taken
	task automatic driveSource(input logic gaps);
		int sent;
		sent = 0;
		while (sent < pixQ.size()) begin
			@(posedge i_clk);
			assert (!(o_pixReady && i_dut.fifoLevel > `WORD_FIFO_DEPTH - 2))
				else reportError("pixel ready high with fewer than two free FIFO slots");
			if (i_pixValid && o_pixReady)
				sent++;
			if (sent >= pixQ.size()) begin
				i_pixValid <= 1'b0;
			end else if (!i_pixValid || o_pixReady) begin
				i_pixValid <= gaps ? lfsrBit() : 1'b1;
				i_pix      <= pixQ[sent];
			end
		end
	endtask

	task automatic drainWords(input testRow_t row);
		logic [31:0] data;
		logic [31:0] want;
		logic [1:0]  resp;
		int          got;
		got = 0;
		if (row.stall == STALL_HOST) begin
			do begin
				readReg(`REG_STATUS, data, resp);
				assert (data[4 +: LVL_W] <= `WORD_FIFO_DEPTH)
					else reportError($sformatf("STATUS level %0d above depth", data[4 +: LVL_W]));
			end while (data[4 +: LVL_W] < `WORD_FIFO_DEPTH - 1);	// Full enough
		end
		while (got < row.groups * wordsPerGroup(row.fmt)) begin
			readReg(`REG_DATA, data, resp);
			if (resp == RESP_SLVERR) begin
				assert (data == 32'd0) else reportError("empty DATA read returned nonzero data");
			end else begin
				assert (expQ.size() > 0) else reportError("model ran out of expected words");
				want = expQ.pop_front();
				assert (data == want)
					else reportError($sformatf("word %0d is %h, expected %h", got, data, want));
				if (row.fmt == FMT_15BIT)
					assert (data[15] == row.mask && data[31] == row.mask)
						else reportError($sformatf("mask bits of %h differ from %b", data, row.mask));
				got++;
			end
		end
		assert (expQ.size() == 0) else reportError("model word count differs from groups rule");
	endtask

	task automatic runRow(input testRow_t row);
		logic [31:0] data;
		logic [31:0] ctrl;
		logic [1:0]  resp;
		buildRow(row);
		ctrl = {28'd0, row.mask, row.fmt, 1'b1};
		writeReg(`REG_GROUPS, {16'd0, row.groups}, resp);
		assert (resp == RESP_OKAY) else reportError("GROUPS write not OKAY");
		writeReg(`REG_CTRL, ctrl, resp);
		fork
			driveSource(row.stall == STALL_SRC);
			begin
				if (row.groups != 16'd0) begin
					readReg(`REG_STATUS, data, resp);
					assert (data[1:0] == 2'b01) else reportError("STATUS not busy after start");
				end
				if (row.restart)
					writeReg(`REG_CTRL, ctrl ^ 32'h6, resp);	// Other format, start ignored
				drainWords(row);
			end
		join
		readReg(`REG_STATUS, data, resp);
		assert (data == 32'h2) else reportError($sformatf("STATUS %h after transfer", data));
		readReg(`REG_DATA, data, resp);
		assert (data == 32'd0 && resp == RESP_SLVERR)
			else reportError("DATA read on empty FIFO not zero with SLVERR");
	endtask

	// Watchdog
	initial begin
		int cycles;
		cycles = 0;
		wait (cycleLimit > 0);
		while (cycles < cycleLimit) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("Timeout: the run went past %0d clock cycles", cycleLimit);
		$display("** FAIL **");
		$fatal(1, "Simulation timed out");
	end

	initial begin
		logic [31:0] data;
		logic [1:0]  resp;
		int          limit;
		i_nrst     = 1'b0;
		i_awvalid  = 1'b0;
		i_awaddr   = '0;
		i_wvalid   = 1'b0;
		i_wdata    = '0;
		i_bready   = 1'b0;
		i_arvalid  = 1'b0;
		i_araddr   = '0;
		i_rready   = 1'b0;
		i_pixValid = 1'b0;
		i_pix      = '0;
		rows[0] = makeRow(FMT_04BIT, 1'b0, 5, STALL_NONE, 1'b0);
		rows[1] = makeRow(FMT_08BIT, 1'b0, 4, STALL_SRC, 1'b0);
		rows[2] = makeRow(FMT_24BIT, 1'b0, 4, STALL_NONE, 1'b1);
		rows[3] = makeRow(FMT_15BIT, 1'b1, 4, STALL_NONE, 1'b0);
		rows[4] = makeRow(FMT_15BIT, 1'b0, 4, STALL_SRC, 1'b0);
		rows[5] = makeRow(FMT_24BIT, 1'b1, 5, STALL_HOST, 1'b0);
		rows[6] = makeRow(FMT_08BIT, 1'b1, 6, STALL_HOST, 1'b0);
		rows[7] = makeRow(FMT_04BIT, 1'b0, 0, STALL_NONE, 1'b0);	// Empty transfer
		rows[8] = makeRow(FMT_04BIT, 1'b0, 10, STALL_HOST, 1'b0);
		limit = 200;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += rows[r].groups * 8 * 4;
		cycleLimit = limit;
		repeat (5) @(posedge i_clk);
		i_nrst <= 1'b1;
		@(posedge i_clk);
		assert ({o_pixReady, o_awready, o_wready, o_bvalid, o_arready, o_rvalid} == 6'd0)
			else reportError("handshake outputs not low after reset");
		readReg(`REG_STATUS, data, resp);
		assert (data == 32'd0 && resp == RESP_OKAY) else reportError("STATUS not zero after reset");
		readReg(`REG_DATA, data, resp);
		assert (data == 32'd0 && resp == RESP_SLVERR) else reportError("empty DATA read not SLVERR");
		readReg(4'h2, data, resp);
		assert (resp == RESP_SLVERR) else reportError("unmapped address not SLVERR");
		for (int r = 0; r < NUM_ROWS; r++)
			runRow(rows[r]);
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== verilog/pixelCounter.sv ====
// Counts the pixels left in a transfer and flags the one that ends it
`timescale 1ns/1ps

module pixelCounter (
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic        i_load,
	input  logic [15:0] i_groups,	// Length in 8-pixel groups
	input  logic        i_accept,
	output logic        o_last,
	output logic        o_zero
);

	logic [18:0] remain;	// Up to 65535 * 8 pixels

	always_ff @(posedge i_clk) begin
		if (!i_nrst)
			remain <= '0;
		else if (i_load)
			remain <= {i_groups, 3'b000};
		else if (i_accept)
			remain <= remain - 19'd1;
	end

	assign o_last = i_accept && (remain == 19'd1);
	// Look through to the new length while loading
	assign o_zero = i_load ? (i_groups == 16'd0) : (remain == 19'd0);

	// Controller must stop ready once the count runs out
	assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_accept |-> (remain != 19'd0))
		else $error("Pixel accepted with no pixels left");

endmodule

// ==== verilog/pixelXferPkg.sv ====
// Shared types of the pixel readback path, imported by the RTL modules that use them
`include "pixelXfer_cfg.svh"

package pixelXferPkg;

	// FIFO fill count runs 0..DEPTH, hence the extra bit
	localparam int LVL_W  = $clog2(`WORD_FIFO_DEPTH) + 1;
	localparam int FREE_W = LVL_W + 1;	// Free slot count seen by the controller

	// Pixel format, same encoding as CTRL bits 2:1
	typedef enum logic [1:0] {
		FMT_04BIT = 2'd0,	// 8 grey pixels per word
		FMT_08BIT = 2'd1,	// 4 grey pixels per word
		FMT_24BIT = 2'd2,	// 4 pixels per 3 words
		FMT_15BIT = 2'd3	// 2 pixels per word
	} pixFmt_e;

	// Transfer FSM states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,	// Accepting pixels
		ST_DRAIN = 2'd2,	// Last word still in flight
		ST_DONE  = 2'd3
	} xferState_e;

	// Incoming pixel, red in the low byte
	typedef struct packed {
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} rgbPix_t;

	// Transfer setup from the host
	typedef struct packed {
		pixFmt_e     fmt;
		logic        setBit15;	// Mask bit for 15-bit words
		logic [15:0] groups;	// Length in groups of 8 pixels
	} xferCfg_t;

	// Status back to the host
	typedef struct packed {
		logic [LVL_W-1:0] level;	// Words waiting in the FIFO
		logic             done;
		logic             busy;
	} xferStat_t;

endpackage

// ==== verilog/pixelXferTop.sv ====
// Top of the pixel readback path, host registers to packed word FIFO
`timescale 1ns/1ps
`include "pixelXfer_cfg.svh"

module pixelXferTop import pixelXferPkg::*; (
	input  logic                    i_clk,
	input  logic                    i_nrst,
	// AXI4-Lite host
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [`XFER_ADDR_W-1:0] i_awaddr,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [31:0]             i_wdata,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [1:0]              o_bresp,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	input  logic [`XFER_ADDR_W-1:0] i_araddr,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic [31:0]             o_rdata,
	output logic [1:0]              o_rresp,
	// Pixel stream from the VRAM reader
	input  logic                    i_pixValid,
	input  rgbPix_t                 i_pix,
	output logic                    o_pixReady
);

	xferCfg_t          cfg;
	xferStat_t         stat;
	logic              start;
	logic              pop;
	logic              load;
	logic              busy;
	logic              done;
	logic              last;
	logic              zero;
	logic              pixAccept;
	logic              wordValid;
	logic [31:0]       packedWord;
	logic [31:0]       fifoData;
	logic [LVL_W-1:0]  fifoLevel;
	logic [FREE_W-1:0] fifoFree;

	assign pixAccept = i_pixValid & o_pixReady;
	assign stat      = '{level: fifoLevel, done: done, busy: busy};

	xferRegs uRegs (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
		.i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
		.o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
		.i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
		.o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
		.i_stat(stat), .i_popData(fifoData),
		.o_cfg(cfg), .o_start(start), .o_pop(pop)
	);

	xferCtrl uCtrl (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_start(start), .i_zero(zero), .i_last(last), .i_fifoFree(fifoFree),
		.o_state(), .o_pixReady(o_pixReady), .o_load(load),
		.o_busy(busy), .o_done(done)
	);

	pixelCounter uCount (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_load(load), .i_groups(cfg.groups), .i_accept(pixAccept),
		.o_last(last), .o_zero(zero)
	);

	rgbPacker uPack (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_clear(load), .i_wrtPix(pixAccept),
		.i_fmt(cfg.fmt), .i_setBit15(cfg.setBit15), .i_pix(i_pix),
		.o_dataValid(wordValid), .o_dataPacked(packedWord)
	);

	wordFifo uFifo (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_push(wordValid), .i_data(packedWord), .i_pop(pop),
		.o_data(fifoData), .o_level(fifoLevel), .o_free(fifoFree)
	);

endmodule

// ==== verilog/pixelXfer_cfg.svh ====
// Build-time sizes and the host register map, included by the package and the RTL modules
`ifndef PIXELXFER_CFG_SVH
`define PIXELXFER_CFG_SVH

// Packed word FIFO depth, power of two (4, 8 or 16 all work)
`define WORD_FIFO_DEPTH	8

// AXI4-Lite byte address width
`define XFER_ADDR_W	4

// Register byte offsets
`define REG_CTRL	4'h0	// W: start, format, mask bit
`define REG_GROUPS	4'h4	// RW: length in 8-pixel groups
`define REG_STATUS	4'h8	// R: busy, done, FIFO level
`define REG_DATA	4'hC	// R: pops one packed word

`endif

// ==== verilog/rgbPacker.sv ====
// Packs accepted RGB pixels into 32-bit words for the selected pixel format
`timescale 1ns/1ps

module rgbPacker import pixelXferPkg::*; (
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic        i_clear,	// New transfer
	input  logic        i_wrtPix,	// Pixel accepted this cycle
	input  pixFmt_e     i_fmt,
	input  logic        i_setBit15,
	input  rgbPix_t     i_pix,
	output logic        o_dataValid,
	output logic [31:0] o_dataPacked
);

	logic [2:0]  phase;	// Pixel index within the packing cycle
	logic [31:0] lanes;	// Pixel bits placed at their word position
	logic [31:0] spill;	// Lanes for the second 24-bit word
	logic [15:0] half15;
	logic [7:0]  nibEn;	// Nibbles of wordLo written by this pixel
	logic [1:0]  hiEn;	// Halves of wordHi written by this pixel
	logic        wordDone;
	logic        useHi;
	logic [31:0] wordLo;
	logic [31:0] wordHi;

	// 15-bit colour, mask bit on top
	assign half15 = {i_setBit15, i_pix.b[7:3], i_pix.g[7:3], i_pix.r[7:3]};
	// Word 1 of a 24-bit group is G1 B1 R2 G2, low byte first
	assign spill  = {i_pix.g, i_pix.r, i_pix.b, i_pix.g};

	always_comb begin
		lanes    = {8{i_pix.r[7:4]}};
		nibEn    = 8'h00;
		hiEn     = 2'b00;
		wordDone = 1'b0;
		case (i_fmt)
		FMT_04BIT: begin
			nibEn    = 8'h01 << phase;
			wordDone = (phase == 3'd7);
		end
		FMT_08BIT: begin
			lanes    = {4{i_pix.r}};
			nibEn    = 8'h03 << {phase[1:0], 1'b0};
			wordDone = (phase[1:0] == 2'd3);
		end
		FMT_24BIT: begin
			// Byte order rotates by one colour every other pixel
			if (phase[1])
				lanes = {i_pix.b, i_pix.g, i_pix.r, i_pix.b};
			else
				lanes = {i_pix.r, i_pix.b, i_pix.g, i_pix.r};
			case (phase[1:0])
			2'd0: nibEn = 8'h3F;	// R0 G0 B0
			2'd1: begin
				nibEn = 8'hC0;	// R1 ends word 0
				hiEn  = 2'b01;	// G1 B1 start word 1
			end
			2'd2: begin
				nibEn = 8'h03;	// B2 opens word 2
				hiEn  = 2'b10;	// R2 G2 end word 1
			end
			default: nibEn = 8'hFC;	// R3 G3 B3
			endcase
			wordDone = (phase[1:0] != 2'd0);
		end
		default: begin
			lanes    = {2{half15}};
			nibEn    = phase[0] ? 8'hF0 : 8'h0F;
			wordDone = phase[0];
		end
		endcase
	end

	// Phase and output strobe
	always_ff @(posedge i_clk) begin
		if (!i_nrst || i_clear) begin
			phase       <= 3'd0;
			o_dataValid <= 1'b0;
			useHi       <= 1'b0;
		end else begin
			o_dataValid <= i_wrtPix && wordDone;
			useHi       <= (i_fmt == FMT_24BIT) && (phase[1:0] == 2'd2);
			if (i_wrtPix)
				phase <= phase + 3'd1;
		end
	end

	// Nibble-enabled word registers
	always_ff @(posedge i_clk) begin
		if (i_wrtPix) begin
			for (int k = 0; k < 8; k++) begin
				if (nibEn[k])
					wordLo[4*k +: 4] <= lanes[4*k +: 4];
			end
			if (hiEn[0])
				wordHi[15:0] <= spill[15:0];
			if (hiEn[1])
				wordHi[31:16] <= spill[31:16];
		end
	end

	assign o_dataPacked = useHi ? wordHi : wordLo;	// Second register only for word 1

endmodule

// ==== verilog/wordFifo.sv ====
// Register FIFO with first-word fall-through holding packed words for the host
`timescale 1ns/1ps
`include "pixelXfer_cfg.svh"

module wordFifo import pixelXferPkg::*; (
	input  logic              i_clk,
	input  logic              i_nrst,
	input  logic              i_push,
	input  logic [31:0]       i_data,
	input  logic              i_pop,
	output logic [31:0]       o_data,	// Head word, valid while level is nonzero
	output logic [LVL_W-1:0]  o_level,
	output logic [FREE_W-1:0] o_free
);

	localparam int DEPTH = `WORD_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	logic [31:0]      mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [LVL_W-1:0] level;

	// Pointers and fill count
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end else begin
			if (i_push)
				wrPtr <= wrPtr + PTR_W'(1);	// Wraps on power-of-two depth
			if (i_pop)
				rdPtr <= rdPtr + PTR_W'(1);
			case ({i_push, i_pop})
			2'b10:   level <= level + LVL_W'(1);
			2'b01:   level <= level - LVL_W'(1);
			default: level <= level;
			endcase
		end
	end

	// Storage
	always_ff @(posedge i_clk) begin
		if (i_push)
			mem[wrPtr] <= i_data;
	end

	assign o_data  = mem[rdPtr];
	assign o_level = level;
	assign o_free  = FREE_W'(DEPTH) - FREE_W'(level);

	// Pixel ready gating must keep a slot for the packer
	assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_push |-> (level != LVL_W'(DEPTH)))
		else $error("Push into full FIFO");

	// Host pops only when STATUS shows a word
	assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_pop |-> (level != '0))
		else $error("Pop from empty FIFO");

endmodule

// ==== verilog/xferCtrl.sv ====
// Transfer FSM instanced by the top level to start, run, drain and complete one pixel readback
`timescale 1ns/1ps

module xferCtrl import pixelXferPkg::*; (
	input  logic              i_clk,
	input  logic              i_nrst,
	input  logic              i_start,	// Accepted CTRL start
	input  logic              i_zero,	// Counter at zero, looked through during load
	input  logic              i_last,	// Last pixel accepted
	input  logic [FREE_W-1:0] i_fifoFree,
	output xferState_e        o_state,
	output logic              o_pixReady,
	output logic              o_load,
	output logic              o_busy,
	output logic              o_done
);

	xferState_e state;
	xferState_e nextState;
	logic       canStart;

	assign canStart = (state == ST_IDLE) || (state == ST_DONE);
	assign o_load   = i_start && canStart;	// Loads counter, clears packer phase

	always_comb begin
		nextState = state;
		case (state)
		ST_IDLE, ST_DONE: begin
			if (o_load)
				nextState = i_zero ? ST_DRAIN : ST_RUN;	// GROUPS = 0 skips RUN
		end
		ST_RUN: begin
			if (i_last)
				nextState = ST_DRAIN;
		end
		ST_DRAIN: nextState = ST_DONE;	// Packer output stage settles
		default:  nextState = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_nrst)
			state <= ST_IDLE;
		else
			state <= nextState;
	end

	// One spare slot kept for a word still leaving the packer
	assign o_pixReady = (state == ST_RUN) && (i_fifoFree >= FREE_W'(2));
	assign o_busy     = (state == ST_RUN) || (state == ST_DRAIN);
	assign o_done     = (state == ST_DONE);
	assign o_state    = state;

	// RUN is left on the last pixel, so the count never hits zero inside it
	assert property (@(posedge i_clk) disable iff (!i_nrst)
		(state == ST_RUN) |-> !i_zero)
		else $error("RUN state held with no pixels left");

endmodule

// ==== verilog/xferRegs.sv ====
// AXI4-Lite slave with the transfer control registers, the status view and the DATA pop port
`timescale 1ns/1ps
`include "pixelXfer_cfg.svh"

module xferRegs import pixelXferPkg::*; (
	input  logic                    i_clk,
	input  logic                    i_nrst,
	// Write address and data, taken together
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [`XFER_ADDR_W-1:0] i_awaddr,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [31:0]             i_wdata,
	// Write response
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [1:0]              o_bresp,
	// Read address and data
	input  logic                    i_arvalid,
	output logic                    o_arready,
	input  logic [`XFER_ADDR_W-1:0] i_araddr,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic [31:0]             o_rdata,
	output logic [1:0]              o_rresp,
	// Core side
	input  xferStat_t               i_stat,
	input  logic [31:0]             i_popData,	// FIFO head, fall-through
	output xferCfg_t                o_cfg,
	output logic                    o_start,
	output logic                    o_pop
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	pixFmt_e     fmtReg;	// Format of the running transfer
	logic        maskReg;
	logic [15:0] groupsReg;
	logic        wrAccept;
	logic        rdAccept;
	logic        wrErr;
	logic        rdErr;
	logic        fifoHasWord;
	logic [31:0] statWord;
	logic [31:0] rdMux;

	assign wrAccept    = o_awready & i_awvalid & o_wready & i_wvalid;
	assign rdAccept    = o_arready & i_arvalid;
	assign fifoHasWord = (i_stat.level != '0);

	// STATUS layout: busy bit 0, done bit 1, level from bit 4
	assign statWord = {{(28 - LVL_W){1'b0}}, i_stat.level, 2'b00, i_stat.done, i_stat.busy};

	// Start is dropped while a transfer is busy
	assign o_start = wrAccept && (i_awaddr == `REG_CTRL) && i_wdata[0] && !i_stat.busy;
	assign o_pop   = rdAccept && (i_araddr == `REG_DATA) && fifoHasWord;	// Head taken now
	assign o_cfg   = '{fmt: fmtReg, setBit15: maskReg, groups: groupsReg};

	// Only CTRL and GROUPS take writes
	assign wrErr = (i_awaddr != `REG_CTRL) && (i_awaddr != `REG_GROUPS);

	// Read data select
	always_comb begin
		rdMux = '0;
		rdErr = 1'b0;
		case (i_araddr)
		`REG_CTRL:   rdMux = {28'd0, maskReg, fmtReg, 1'b0};	// Start reads back as 0
		`REG_GROUPS: rdMux = {16'd0, groupsReg};
		`REG_STATUS: rdMux = statWord;
		`REG_DATA: begin
			if (fifoHasWord)
				rdMux = i_popData;
			else
				rdErr = 1'b1;	// Empty FIFO, zero data
		end
		default:     rdErr = 1'b1;
		endcase
	end

	// Write channel and the host registers
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			o_bvalid  <= 1'b0;
			o_bresp   <= RESP_OKAY;
			fmtReg    <= FMT_04BIT;
			maskReg   <= 1'b0;
			groupsReg <= '0;
		end else begin
			// One-cycle ready pulse once both channels are up
			o_awready <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
			o_wready  <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			if (wrAccept) begin
				o_bvalid <= 1'b1;
				o_bresp  <= wrErr ? RESP_SLVERR : RESP_OKAY;
				if (o_start) begin
					fmtReg  <= pixFmt_e'(i_wdata[2:1]);	// Latched with the start
					maskReg <= i_wdata[3];
				end
				if (i_awaddr == `REG_GROUPS)
					groupsReg <= i_wdata[15:0];
			end
		end
	end

	// Read channel control
	always_ff @(posedge i_clk) begin
		if (!i_nrst) begin
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
			o_rresp   <= RESP_OKAY;
		end else begin
			o_arready <= i_arvalid & ~o_arready & ~o_rvalid;	// One read in flight
			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
			if (rdAccept) begin
				o_rvalid <= 1'b1;
				o_rresp  <= rdErr ? RESP_SLVERR : RESP_OKAY;
			end
		end
	end

	// Read payload
	always_ff @(posedge i_clk) begin
		if (rdAccept)
			o_rdata <= rdMux;
	end

	// Response held steady until the host takes it
	assert property (@(posedge i_clk) disable iff (!i_nrst)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata))
		else $error("RVALID or RDATA changed before RREADY");

endmodule
